/* Bender.yml */
package:
  name: ddr3_dfi_phy

sources:
  - files:
      - logic/ddr3_phy_pkg.sv
      - logic/ddr3_lane_if.sv
      - logic/ddr3_out_stage.sv
      - logic/ddr3_byte_lane.sv
      - logic/ddr3_rd_align.sv
      - logic/ddr3_dfi_phy.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_ddr3_dfi_phy.sv

/* files.f */
+incdir+include
logic/ddr3_phy_pkg.sv
logic/ddr3_lane_if.sv
logic/ddr3_out_stage.sv
logic/ddr3_byte_lane.sv
logic/ddr3_rd_align.sv
logic/ddr3_dfi_phy.sv
verification/tb_ddr3_dfi_phy.sv

/* logic/ddr3_byte_lane.sv */
// DDR3 byte lane: DDR output of write and mask beats, DDR capture of read beats
module ddr3_byte_lane (
    input  logic                     clk_i,
    input  logic                     rst_i,
    ddr3_lane_if.lane                lane,
    output ddr3_phy_pkg::lane_byte_t dq_o,
    output logic                     dm_o,
    input  ddr3_phy_pkg::lane_byte_t dq_i
);
    import ddr3_phy_pkg::*;

    lane_byte_t wr_rise_q;
    lane_byte_t wr_fall_q;
    logic       dm_rise_q;
    logic       dm_fall_q;

    lane_byte_t rd_rise_cap;
    lane_byte_t rd_fall_cap;
    lane_byte_t rd_rise_q;
    lane_byte_t rd_fall_q;

    // ----------------------------------------------------------
    // DDR output
    // ----------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wr_rise_q <= '0;
            wr_fall_q <= '0;
            dm_rise_q <= 1'b0;
            dm_fall_q <= 1'b0;
        end
        else
        begin
            wr_rise_q <= lane.wr_rise;
            wr_fall_q <= lane.wr_fall;
            dm_rise_q <= lane.dm_rise;
            dm_fall_q <= lane.dm_fall;
        end
    end

    // High phase shows the rising beat, low phase the falling beat
    assign dq_o = clk_i ? wr_rise_q : wr_fall_q;
    assign dm_o = clk_i ? dm_rise_q : dm_fall_q;

    // ----------------------------------------------------------
    // DDR capture
    // ----------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        rd_rise_cap <= dq_i;
    end

    always_ff @(negedge clk_i)
    begin
        rd_fall_cap <= dq_i;
    end

    // Both beats land together on the next rising edge
    always_ff @(posedge clk_i)
    begin
        rd_rise_q <= rd_rise_cap;
        rd_fall_q <= rd_fall_cap;
    end

    assign lane.rd_rise = rd_rise_q;
    assign lane.rd_fall = rd_fall_q;

    a_dq_known_when_oe: assert property (
        @(posedge clk_i) disable iff (rst_i)
        lane.oe |-> !$isunknown(dq_o)
    ) else $error("unknown write data on DQ while output is enabled");

endmodule

/* logic/ddr3_dfi_phy.sv */
// DDR3 DFI PHY top: DFI command and data to a 16-bit DDR pin bus and back
module ddr3_dfi_phy #(
    parameter int unsigned TPHY_RDLAT = 4
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                cfg_valid_i,
    input  logic [ddr3_phy_pkg::CFG_W-1:0]      cfg_i,
    input  logic [ddr3_phy_pkg::ADDR_W-1:0]     dfi_address_i,
    input  logic [ddr3_phy_pkg::BANK_W-1:0]     dfi_bank_i,
    input  logic                                dfi_cas_n_i,
    input  logic                                dfi_cke_i,
    input  logic                                dfi_cs_n_i,
    input  logic                                dfi_odt_i,
    input  logic                                dfi_ras_n_i,
    input  logic                                dfi_reset_n_i,
    input  logic                                dfi_we_n_i,
    input  ddr3_phy_pkg::dfi_data_t             dfi_wrdata_i,
    input  logic                                dfi_wrdata_en_i,
    input  ddr3_phy_pkg::dfi_mask_t             dfi_wrdata_mask_i,
    input  logic                                dfi_rddata_en_i,
    input  ddr3_phy_pkg::dq_t                   ddr3_dq_i,
    output ddr3_phy_pkg::dfi_data_t             dfi_rddata_o,
    output logic                                dfi_rddata_valid_o,
    output logic                                ddr3_cke_o,
    output logic                                ddr3_reset_n_o,
    output logic                                ddr3_ras_n_o,
    output logic                                ddr3_cas_n_o,
    output logic                                ddr3_we_n_o,
    output logic                                ddr3_cs_n_o,
    output logic                                ddr3_odt_o,
    output logic [ddr3_phy_pkg::BANK_W-1:0]     ddr3_ba_o,
    output logic [ddr3_phy_pkg::ADDR_W-1:0]     ddr3_addr_o,
    output logic [ddr3_phy_pkg::NUM_LANES-1:0]  ddr3_dm_o,
    output ddr3_phy_pkg::dq_t                   ddr3_dq_o,
    output logic                                ddr3_dq_oe_o
);
    import ddr3_phy_pkg::*;

    ddr3_cmd_t dfi_cmd;
    ddr3_cmd_t ddr3_cmd;

    ddr3_lane_if lane_if [NUM_LANES] ();

    // ----------------------------------------------------------
    // Command packing
    // ----------------------------------------------------------
    assign dfi_cmd.cke     = dfi_cke_i;
    assign dfi_cmd.reset_n = dfi_reset_n_i;
    assign dfi_cmd.ras_n   = dfi_ras_n_i;
    assign dfi_cmd.cas_n   = dfi_cas_n_i;
    assign dfi_cmd.we_n    = dfi_we_n_i;
    assign dfi_cmd.cs_n    = dfi_cs_n_i;
    assign dfi_cmd.odt     = dfi_odt_i;
    assign dfi_cmd.bank    = dfi_bank_i;
    assign dfi_cmd.address = dfi_address_i;

    assign ddr3_cke_o     = ddr3_cmd.cke;
    assign ddr3_reset_n_o = ddr3_cmd.reset_n;
    assign ddr3_ras_n_o   = ddr3_cmd.ras_n;
    assign ddr3_cas_n_o   = ddr3_cmd.cas_n;
    assign ddr3_we_n_o    = ddr3_cmd.we_n;
    assign ddr3_cs_n_o    = ddr3_cmd.cs_n;
    assign ddr3_odt_o     = ddr3_cmd.odt;
    assign ddr3_ba_o      = ddr3_cmd.bank;
    assign ddr3_addr_o    = ddr3_cmd.address;

    // ----------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------
    ddr3_out_stage u_out_stage (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .dfi_cmd_i         (dfi_cmd),
        .dfi_wrdata_i      (dfi_wrdata_i),
        .dfi_wrdata_mask_i (dfi_wrdata_mask_i),
        .dfi_wrdata_en_i   (dfi_wrdata_en_i),
        .ddr3_cmd_o        (ddr3_cmd),
        .lanes             (lane_if)
    );

    for (genvar g = 0; g < NUM_LANES; g++)
    begin : g_byte_lane
        ddr3_byte_lane u_lane (
            .clk_i (clk_i),
            .rst_i (rst_i),
            .lane  (lane_if[g]),
            .dq_o  (ddr3_dq_o[g*LANE_W +: LANE_W]),
            .dm_o  (ddr3_dm_o[g]),
            .dq_i  (ddr3_dq_i[g*LANE_W +: LANE_W])
        );
    end

    // All lanes share one enable
    assign ddr3_dq_oe_o = lane_if[0].oe;

    ddr3_rd_align #(
        .TPHY_RDLAT (TPHY_RDLAT)
    ) u_rd_align (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .cfg_valid_i        (cfg_valid_i),
        .cfg_i              (cfg_i),
        .dfi_rddata_en_i    (dfi_rddata_en_i),
        .lanes              (lane_if),
        .dfi_rddata_o       (dfi_rddata_o),
        .dfi_rddata_valid_o (dfi_rddata_valid_o)
    );

endmodule

/* logic/ddr3_lane_if.sv */
// DDR3 byte lane bundle: write beats, mask beats, output enable, read beats
interface ddr3_lane_if;
    import ddr3_phy_pkg::*;

    // Write beats of the current clock
    lane_byte_t wr_rise;
    lane_byte_t wr_fall;
    logic       dm_rise;
    logic       dm_fall;
    logic       oe;

    // Read beats retimed to the rising edge
    lane_byte_t rd_rise;
    lane_byte_t rd_fall;

    modport src (
        output wr_rise, wr_fall, dm_rise, dm_fall, oe
    );

    modport lane (
        input  wr_rise, wr_fall, dm_rise, dm_fall, oe,
        output rd_rise, rd_fall
    );

    modport sink (
        input rd_rise, rd_fall
    );

endinterface

/* logic/ddr3_out_stage.sv */
// DDR3 PHY output stage: command and write registers, write OE, lane split
module ddr3_out_stage (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  ddr3_phy_pkg::ddr3_cmd_t dfi_cmd_i,
    input  ddr3_phy_pkg::dfi_data_t dfi_wrdata_i,
    input  ddr3_phy_pkg::dfi_mask_t dfi_wrdata_mask_i,
    input  logic                    dfi_wrdata_en_i,
    output ddr3_phy_pkg::ddr3_cmd_t ddr3_cmd_o,
    ddr3_lane_if.src                lanes [ddr3_phy_pkg::NUM_LANES]
);
    import ddr3_phy_pkg::*;

    ddr3_cmd_t  cmd_q;
    dfi_data_t  wrdata_q;
    dfi_mask_t  mask_q;
    logic [2:0] wr_hist_q;
    logic       oe_q;

    // ----------------------------------------------------------
    // Command and write word registers
    // ----------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            cmd_q    <= '0;
            wrdata_q <= '0;
            mask_q   <= '0;
        end
        else
        begin
            cmd_q    <= dfi_cmd_i;
            wrdata_q <= dfi_wrdata_i;
            mask_q   <= dfi_wrdata_mask_i;
        end
    end

    assign ddr3_cmd_o = cmd_q;

    // ----------------------------------------------------------
    // Write output enable
    // ----------------------------------------------------------
    // Bit 0 is the newest sample of the write enable
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wr_hist_q <= '0;
        end
        else
        begin
            wr_hist_q <= {wr_hist_q[1:0], dfi_wrdata_en_i};
        end
    end

    // Set from stage 1, held until stage 2 drains
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            oe_q <= 1'b0;
        else if (wr_hist_q[1])
            oe_q <= 1'b1;
        else if (!wr_hist_q[2])
            oe_q <= 1'b0;
    end

    // ----------------------------------------------------------
    // Lane distribution
    // ----------------------------------------------------------
    for (genvar l = 0; l < NUM_LANES; l++)
    begin : g_lane
        assign lanes[l].wr_rise = wrdata_q[l*LANE_W +: LANE_W];
        assign lanes[l].wr_fall = wrdata_q[DQ_W + l*LANE_W +: LANE_W];
        assign lanes[l].dm_rise = mask_q[l];
        assign lanes[l].dm_fall = mask_q[l + NUM_LANES];
        assign lanes[l].oe      = oe_q;
    end

    // OE rise is visible one edge after it happens, hence three samples back
    a_oe_after_en: assert property (
        @(posedge clk_i) disable iff (rst_i)
        $rose(oe_q) |-> $past(dfi_wrdata_en_i, 3)
    ) else $error("write OE rose without a write enable two edges before");

endmodule

/* logic/ddr3_phy_pkg.sv */
// DDR3 DFI PHY shared widths, lane constants and DFI command type
package ddr3_phy_pkg;

    // ----------------------------------------------------------
    // Pin and lane geometry
    // ----------------------------------------------------------
    localparam int DQ_W       = 16;
    localparam int LANE_W     = 8;
    localparam int NUM_LANES  = DQ_W / LANE_W;

    // DFI side carries both beats in one word
    localparam int DFI_DATA_W = 2 * DQ_W;
    localparam int DFI_MASK_W = 2 * NUM_LANES;

    // Command field widths
    localparam int ADDR_W     = 15;
    localparam int BANK_W     = 3;

    // ----------------------------------------------------------
    // Read latency and configuration word
    // ----------------------------------------------------------
    localparam int RD_LAT_W      = 4;
    localparam int RD_SHIFT_W    = 12;
    localparam int CFG_RDLAT_LSB = 8;
    localparam int CFG_W         = 32;

    // ----------------------------------------------------------
    // Types
    // ----------------------------------------------------------
    typedef logic [DFI_DATA_W-1:0] dfi_data_t;
    typedef logic [DFI_MASK_W-1:0] dfi_mask_t;
    typedef logic [DQ_W-1:0]       dq_t;
    typedef logic [LANE_W-1:0]     lane_byte_t;
    typedef logic [RD_LAT_W-1:0]   rd_lat_t;

    // One DFI command as driven to the DDR3 pins
    typedef struct packed {
        logic              cke;
        logic              reset_n;
        logic              ras_n;
        logic              cas_n;
        logic              we_n;
        logic              cs_n;
        logic              odt;
        logic [BANK_W-1:0] bank;
        logic [ADDR_W-1:0] address;
    } ddr3_cmd_t;

endpackage

/* logic/ddr3_rd_align.sv */
// DDR3 PHY read side: read latency register, valid delay line, word assembly
module ddr3_rd_align #(
    parameter int unsigned TPHY_RDLAT = 4
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           cfg_valid_i,
    input  logic [ddr3_phy_pkg::CFG_W-1:0] cfg_i,
    input  logic                           dfi_rddata_en_i,
    ddr3_lane_if.sink                      lanes [ddr3_phy_pkg::NUM_LANES],
    output ddr3_phy_pkg::dfi_data_t        dfi_rddata_o,
    output logic                           dfi_rddata_valid_o
);
    import ddr3_phy_pkg::*;

    rd_lat_t               rd_lat_q;
    rd_lat_t               cfg_lat;
    logic [RD_SHIFT_W-1:0] rd_en_q;
    logic [RD_SHIFT_W-1:0] rd_en_d;

    // ----------------------------------------------------------
    // Read latency
    // ----------------------------------------------------------
    assign cfg_lat = cfg_i[CFG_RDLAT_LSB +: RD_LAT_W];

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            rd_lat_q <= rd_lat_t'(TPHY_RDLAT);
        else if (cfg_valid_i)
            rd_lat_q <= cfg_lat;
    end

    // ----------------------------------------------------------
    // Read valid delay line
    // ----------------------------------------------------------
    // Enable enters at stage L and walks down to stage 0
    always_comb
    begin
        rd_en_d = {1'b0, rd_en_q[RD_SHIFT_W-1:1]};
        if (rd_lat_q < RD_SHIFT_W)
            rd_en_d[rd_lat_q] = dfi_rddata_en_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            rd_en_q <= '0;
        else
            rd_en_q <= rd_en_d;
    end

    assign dfi_rddata_valid_o = rd_en_q[0];

    // Falling beats form the upper half of the DFI word
    for (genvar l = 0; l < NUM_LANES; l++)
    begin : g_lane
        assign dfi_rddata_o[l*LANE_W +: LANE_W]        = lanes[l].rd_rise;
        assign dfi_rddata_o[DQ_W + l*LANE_W +: LANE_W] = lanes[l].rd_fall;
    end

    a_rdlat_in_range: assert property (
        @(posedge clk_i) disable iff (rst_i)
        cfg_valid_i |-> (cfg_lat < RD_SHIFT_W)
    ) else $error("read latency %0d beyond the valid delay line", cfg_lat);

endmodule

/* include/tb_ddr3_checks.svh */
// DDR3 PHY testbench reference model for pin beats and typed result compares
`ifndef TB_DDR3_CHECKS_SVH
`define TB_DDR3_CHECKS_SVH

// One pin beat as seen on DQ and DM
typedef struct packed {
    logic [ddr3_phy_pkg::NUM_LANES-1:0] dm;
    ddr3_phy_pkg::dq_t                  dq;
} pin_beat_t;

// ----------------------------------------------------------
// Reference model
// ----------------------------------------------------------
// Falling beat takes the upper half of word and mask
function automatic pin_beat_t exp_pin_beat(
    input ddr3_phy_pkg::dfi_data_t data,
    input ddr3_phy_pkg::dfi_mask_t mask,
    input bit                      fall_sel
);
    pin_beat_t beat;
    if (fall_sel)
    begin
        beat.dq = data[ddr3_phy_pkg::DFI_DATA_W-1:ddr3_phy_pkg::DQ_W];
        beat.dm = mask[ddr3_phy_pkg::DFI_MASK_W-1:ddr3_phy_pkg::NUM_LANES];
    end
    else
    begin
        beat.dq = data[ddr3_phy_pkg::DQ_W-1:0];
        beat.dm = mask[ddr3_phy_pkg::NUM_LANES-1:0];
    end
    return beat;
endfunction

// ----------------------------------------------------------
// Typed compares
// ----------------------------------------------------------
task automatic cmd_compare(
    input string                   name,
    input ddr3_phy_pkg::ddr3_cmd_t got,
    input ddr3_phy_pkg::ddr3_cmd_t exp
);
    if (got !== exp)
        abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
endtask

task automatic beat_compare(input string name, input pin_beat_t got, input pin_beat_t exp);
    if (got !== exp)
        abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
endtask

task automatic rddata_compare(
    input string                   name,
    input ddr3_phy_pkg::dfi_data_t got,
    input ddr3_phy_pkg::dfi_data_t exp
);
    if (got !== exp)
        abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
endtask

task automatic bit_compare(input string name, input logic got, input logic exp);
    if (got !== exp)
        abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
endtask

`endif

/* verification/tb_ddr3_dfi_phy.sv */
// DDR3 DFI PHY testbench: random command, write, read capture and read latency traffic
module tb_ddr3_dfi_phy;
    import ddr3_phy_pkg::*;

    `include "tb_ddr3_checks.svh"

    localparam int          HALF_PERIOD = 4;
    localparam int          RST_CYCLES  = 2;
    localparam int          DEF_RDLAT   = 4;
    localparam int unsigned SEED        = 32'h0d267c5c;
    localparam int          CMD_W       = $bits(ddr3_cmd_t);

    localparam int N_CMD     = 200;
    localparam int N_BURST   = 40;
    localparam int MAX_BURST = 6;
    localparam int MAX_GAP   = 4;
    localparam int N_RD      = 100;
    localparam int N_RDEN    = 40;
    localparam int N_CFG     = 8;
    localparam int DRAIN     = RD_SHIFT_W + 2;

    localparam int TEST_CYCLES = RST_CYCLES + N_CMD + N_BURST * (MAX_BURST + MAX_GAP)
                               + N_RD + (N_CFG + 1) * (N_RDEN + DRAIN + 2) + 8;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    // Expected DUT state in the cycle after one rising edge
    typedef struct {
        ddr3_cmd_t cmd;
        pin_beat_t hi;
        pin_beat_t lo;
        logic      oe;
        logic      valid;
        dfi_data_t rd;
        bit        rd_chk;
    } exp_cycle_t;

    logic                 clk_i;
    logic                 rst_i;
    logic                 cfg_valid_i;
    logic [CFG_W-1:0]     cfg_i;
    logic [ADDR_W-1:0]    dfi_address_i;
    logic [BANK_W-1:0]    dfi_bank_i;
    logic                 dfi_cas_n_i;
    logic                 dfi_cke_i;
    logic                 dfi_cs_n_i;
    logic                 dfi_odt_i;
    logic                 dfi_ras_n_i;
    logic                 dfi_reset_n_i;
    logic                 dfi_we_n_i;
    dfi_data_t            dfi_wrdata_i;
    logic                 dfi_wrdata_en_i;
    dfi_mask_t            dfi_wrdata_mask_i;
    logic                 dfi_rddata_en_i;
    dq_t                  ddr3_dq_i;
    dfi_data_t            dfi_rddata_o;
    logic                 dfi_rddata_valid_o;
    logic                 ddr3_cke_o;
    logic                 ddr3_reset_n_o;
    logic                 ddr3_ras_n_o;
    logic                 ddr3_cas_n_o;
    logic                 ddr3_we_n_o;
    logic                 ddr3_cs_n_o;
    logic                 ddr3_odt_o;
    logic [BANK_W-1:0]    ddr3_ba_o;
    logic [ADDR_W-1:0]    ddr3_addr_o;
    logic [NUM_LANES-1:0] ddr3_dm_o;
    dq_t                  ddr3_dq_o;
    logic                 ddr3_dq_oe_o;

    ddr3_cmd_t  dfi_cmd;
    ddr3_cmd_t  pin_cmd;
    exp_cycle_t exp_q [$];
    int         cycle_count = 0;

    // Reference model state
    dfi_data_t  wr_s1;
    dfi_data_t  wr_s2;
    dfi_mask_t  mk_s1;
    dfi_mask_t  mk_s2;
    logic [3:0] en_hist;
    int         cur_lat;
    bit         valid_sched [64];
    dq_t        rise_cap;
    dq_t        fall_cap;
    int         cap_count = 0;
    int         cyc = 0;

    assign {dfi_cke_i, dfi_reset_n_i, dfi_ras_n_i, dfi_cas_n_i, dfi_we_n_i, dfi_cs_n_i,
            dfi_odt_i, dfi_bank_i, dfi_address_i} = dfi_cmd;
    assign pin_cmd = {ddr3_cke_o, ddr3_reset_n_o, ddr3_ras_n_o, ddr3_cas_n_o, ddr3_we_n_o,
                      ddr3_cs_n_o, ddr3_odt_o, ddr3_ba_o, ddr3_addr_o};

    ddr3_dfi_phy #(
        .TPHY_RDLAT (DEF_RDLAT)
    ) dut0 (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #HALF_PERIOD clk_i = ~clk_i;
    end

    // ----------------------------------------------------------
    // Failure reporting and timeout
    // ----------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "run stopped at first error");
    endtask

    always @(posedge clk_i)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
            abort_run($sformatf("timeout: run did not end within %0d cycles", CYCLE_LIMIT));
    end

    // ----------------------------------------------------------
    // Reference model sampling inputs at the same edges as the DUT
    // ----------------------------------------------------------
    always @(posedge clk_i)
    begin
        exp_cycle_t e;
        if (rst_i)
        begin
            e.cmd       = '0;
            wr_s1       = '0;
            wr_s2       = '0;
            mk_s1       = '0;
            mk_s2       = '0;
            en_hist     = '0;
            cur_lat     = DEF_RDLAT;
            valid_sched = '{default: 1'b0};
        end
        else
        begin
            e.cmd   = dfi_cmd;
            wr_s2   = wr_s1;
            mk_s2   = mk_s1;
            wr_s1   = dfi_wrdata_i;
            mk_s1   = dfi_wrdata_mask_i;
            en_hist = {en_hist[2:0], dfi_wrdata_en_i};
            if (dfi_rddata_en_i)
                valid_sched[(cyc + cur_lat) % 64] = 1'b1;
            if (cfg_valid_i)
                cur_lat = int'(cfg_i[CFG_RDLAT_LSB +: RD_LAT_W]);
        end
        e.hi    = exp_pin_beat(wr_s2, mk_s2, 1'b0);
        e.lo    = exp_pin_beat(wr_s2, mk_s2, 1'b1);
        // Each write enable holds OE for the 2nd and 3rd cycle after it
        e.oe    = en_hist[2] | en_hist[3];
        e.valid = valid_sched[cyc % 64];
        valid_sched[cyc % 64] = 1'b0;
        e.rd     = {fall_cap, rise_cap};
        e.rd_chk = (cap_count >= 1);
        rise_cap = ddr3_dq_i;
        cap_count++;
        cyc++;
        exp_q.push_back(e);
    end

    always @(negedge clk_i)
    begin
        fall_cap = ddr3_dq_i;
    end

    // Outputs are compared in the middle of each clock phase
    initial
    begin
        exp_cycle_t e;
        forever
        begin
            @(posedge clk_i);
            #(HALF_PERIOD / 2);
            if (exp_q.size() == 0)
                abort_run("compare process found no expected values for this cycle");
            else
                e = exp_q.pop_front();
            cmd_compare("ddr3 command", pin_cmd, e.cmd);
            beat_compare("ddr3_dm_o/ddr3_dq_o high phase", {ddr3_dm_o, ddr3_dq_o}, e.hi);
            bit_compare("ddr3_dq_oe_o", ddr3_dq_oe_o, e.oe);
            bit_compare("dfi_rddata_valid_o", dfi_rddata_valid_o, e.valid);
            if (e.rd_chk)
                rddata_compare("dfi_rddata_o", dfi_rddata_o, e.rd);
            @(negedge clk_i);
            #(HALF_PERIOD / 2);
            beat_compare("ddr3_dm_o/ddr3_dq_o low phase", {ddr3_dm_o, ddr3_dq_o}, e.lo);
        end
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    initial
    begin
        int               burst_len;
        int               gap_len;
        int               lat;
        logic [CFG_W-1:0] cfg_word;
        void'($urandom(SEED));
        rst_i             = 1'b1;
        cfg_valid_i       = 1'b0;
        cfg_i             = '0;
        dfi_cmd           = '0;
        dfi_wrdata_i      = '0;
        dfi_wrdata_en_i   = 1'b0;
        dfi_wrdata_mask_i = '0;
        dfi_rddata_en_i   = 1'b0;
        ddr3_dq_i         = '0;

        repeat (RST_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        #(HALF_PERIOD / 2);
        cmd_compare("ddr3 command after reset", pin_cmd, '0);
        bit_compare("ddr3_dq_oe_o after reset", ddr3_dq_oe_o, 1'b0);
        bit_compare("dfi_rddata_valid_o after reset", dfi_rddata_valid_o, 1'b0);

        repeat (N_CMD)
        begin
            @(posedge clk_i);
            dfi_cmd <= CMD_W'($urandom);
        end

        // Write bursts where a zero gap joins two bursts
        repeat (N_BURST)
        begin
            burst_len = 1 + $urandom % MAX_BURST;
            gap_len   = $urandom % (MAX_GAP + 1);
            repeat (burst_len)
            begin
                @(posedge clk_i);
                dfi_wrdata_i      <= $urandom;
                dfi_wrdata_mask_i <= dfi_mask_t'($urandom);
                dfi_wrdata_en_i   <= 1'b1;
            end
            repeat (gap_len)
            begin
                @(posedge clk_i);
                dfi_wrdata_i    <= $urandom;
                dfi_wrdata_en_i <= 1'b0;
            end
        end
        @(posedge clk_i);
        dfi_wrdata_en_i <= 1'b0;

        // DDR read beats on both edges
        repeat (N_RD)
        begin
            @(posedge clk_i);
            ddr3_dq_i <= dq_t'($urandom);
            @(negedge clk_i);
            ddr3_dq_i <= dq_t'($urandom);
        end

        // Default latency first, then one run per written latency
        for (int n = 0; n <= N_CFG; n++)
        begin
            if (n > 0)
            begin
                lat = (n == 1) ? 0 : (n == 2) ? RD_SHIFT_W - 1 : $urandom % RD_SHIFT_W;
                cfg_word = $urandom;
                cfg_word[CFG_RDLAT_LSB +: RD_LAT_W] = rd_lat_t'(lat);
                @(posedge clk_i);
                cfg_valid_i <= 1'b1;
                cfg_i       <= cfg_word;
                @(posedge clk_i);
                cfg_valid_i <= 1'b0;
            end
            repeat (N_RDEN)
            begin
                @(posedge clk_i);
                dfi_rddata_en_i <= ($urandom % 3 == 0);
            end
            @(posedge clk_i);
            dfi_rddata_en_i <= 1'b0;
            repeat (DRAIN) @(posedge clk_i);
        end

        repeat (4) @(posedge clk_i);
        $display("All tests passed!");
        $finish;
    end

endmodule
